// ==== icache_top.f ====
logic/icache_pkg.sv
logic/icache_sram.sv
logic/icache_tag_store.sv
logic/icache_data_store.sv
logic/icache_victim_sel.sv
logic/icache_ctrl.sv
logic/icache_top.sv
tb/icache_assertions.sv
tb/icache_tb.sv

// ==== logic/icache_ctrl.sv ====
`default_nettype none

module icache_ctrl
  import icache_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   en_i,
  // fetch port
  input  logic                   fetch_req_valid_i,
  input  fetch_req_t             fetch_req_i,
  output logic                   fetch_req_ready_o,
  output logic                   fetch_rsp_valid_o,
  // refill port
  output logic                   refill_req_valid_o,
  output refill_req_t            refill_req_o,
  input  logic                   refill_req_ready_i,
  input  logic                   refill_rsp_valid_i,
  // from tag store
  input  logic                   hit_i,
  // to the stores
  output logic                   rd_en_o,
  output logic                   wr_en_o,
  output logic                   flush_en_o,
  output logic                   sample_o,
  output logic                   use_refill_o,
  output logic [IndexWidth-1:0]  index_o,
  output logic [OffsetWidth-1:0] offset_o,
  output logic [TagWidth-1:0]    tag_o
);

  ctrl_state_e           state_d;
  ctrl_state_e           state_q;
  logic                  cache_en_d;
  logic                  cache_en_q;
  // pending flush
  logic                  flush_d;
  logic                  flush_q;
  logic [IndexWidth-1:0] flush_cnt_q;
  logic                  flush_done;
  logic [AddrWidth-1:0]  addr_d;
  logic [AddrWidth-1:0]  addr_q;
  logic                  take;
  logic                  hit;

  ////////////////////
  // address latch
  ////////////////////

  assign take   = fetch_req_valid_i & fetch_req_ready_o;
  assign addr_d = take ? fetch_req_i.addr : addr_q;

  // arrays see the new index in the cycle the request is taken
  assign index_o  = (state_q == FLUSH) ? flush_cnt_q : addr_d[OffsetWidth +: IndexWidth];
  assign tag_o    = addr_q[AddrWidth-1 -: TagWidth];
  assign offset_o = addr_q[OffsetWidth-1:0];

  // line aligned refill address
  assign refill_req_o.addr = {addr_q[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};

  // no lookup while disabled
  assign rd_en_o = take & cache_en_q;
  // a disabled cache never hits, so it goes down the miss path
  assign hit     = hit_i & cache_en_q;

  assign flush_done = (flush_cnt_q == IndexWidth'(NumSets - 1));

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d    = state_q;
    // turning off is immediate, turning on goes through flush
    cache_en_d = cache_en_q & en_i;
    flush_d    = flush_q | flush_i;

    fetch_req_ready_o  = 1'b0;
    fetch_rsp_valid_o  = 1'b0;
    refill_req_valid_o = 1'b0;
    wr_en_o            = 1'b0;
    flush_en_o         = 1'b0;
    sample_o           = 1'b0;
    use_refill_o       = 1'b0;

    unique case (state_q)
      IDLE: begin
        // pending flush or enable rising edge clears first
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else begin
          fetch_req_ready_o = 1'b1;
          if (fetch_req_valid_i) begin
            state_d = READ;
          end
        end
      end
      READ: begin
        // tag data valid now, victim gets sampled
        sample_o = 1'b1;
        if (hit) begin
          fetch_rsp_valid_o = 1'b1;
          state_d           = IDLE;
          // back to back lookup unless a flush waits
          if (!flush_d) begin
            fetch_req_ready_o = 1'b1;
            if (fetch_req_valid_i) begin
              state_d = READ;
            end
          end
        end else begin
          // hold here until memory takes the request
          refill_req_valid_o = 1'b1;
          if (refill_req_ready_i) begin
            state_d = MISS;
          end
        end
      end
      MISS: begin
        // word comes straight from the refill line
        if (refill_rsp_valid_i) begin
          fetch_rsp_valid_o = 1'b1;
          use_refill_o      = 1'b1;
          // store only while enabled
          wr_en_o           = cache_en_q;
          state_d           = IDLE;
        end
      end
      FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      addr_q      <= '0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      addr_q     <= addr_d;
      // walks all sets once per flush
      if (flush_en_o) begin
        flush_cnt_q <= flush_done ? '0 : flush_cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/icache_data_store.sv ====
`default_nettype none

module icache_data_store
  import icache_pkg::*;
#(
  parameter  int unsigned NumWays  = 4,
  localparam int unsigned WayWidth = $clog2(NumWays)
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rd_en_i,
  input  logic                   we_i,
  input  logic [NumWays-1:0]     way_oh_i,
  input  logic [IndexWidth-1:0]  index_i,
  input  logic [OffsetWidth-1:0] offset_i,
  input  refill_rsp_t            refill_i,
  input  logic [WayWidth-1:0]    hit_way_i,
  input  logic                   use_refill_i,
  output fetch_rsp_t             word_o
);

  // byte bits below a word are ignored
  localparam int unsigned ByteSelWidth = $clog2(FetchWidth / 8);

  line_t                                 rdata [NumWays];
  logic [OffsetWidth-ByteSelWidth-1:0]   word_idx;
  logic [FetchWidth-1:0]                 hit_word;
  logic [FetchWidth-1:0]                 refill_word;

  // one line array per way, written with the refill line
  for (genvar i = 0; i < NumWays; i++) begin : gen_way
    icache_sram #(
      .entry_t ( line_t  ),
      .Depth   ( NumSets )
    ) u_line_sram (
      .clk_i   ( clk_i                          ),
      .rst_ni  ( rst_ni                         ),
      .req_i   ( rd_en_i | (we_i & way_oh_i[i]) ),
      .we_i    ( we_i                           ),
      .addr_i  ( index_i                        ),
      .wdata_i ( refill_i.data                  ),
      .rdata_o ( rdata[i]                       )
    );
  end

  ////////////////////
  // word select
  ////////////////////

  assign word_idx    = offset_i[OffsetWidth-1:ByteSelWidth];
  assign hit_word    = rdata[hit_way_i][word_idx*FetchWidth +: FetchWidth];
  // refill word bypasses the array
  assign refill_word = refill_i.data[word_idx*FetchWidth +: FetchWidth];

  assign word_o.data = use_refill_i ? refill_word : hit_word;

endmodule

`default_nettype wire

// ==== logic/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  ////////////////////
  // geometry
  ////////////////////

  // physical byte address
  localparam int unsigned AddrWidth   = 16;
  // one instruction word per fetch
  localparam int unsigned FetchWidth  = 32;
  // line size in bytes and bits
  localparam int unsigned LineBytes   = 16;
  localparam int unsigned LineWidth   = LineBytes * 8;
  localparam int unsigned OffsetWidth = $clog2(LineBytes);
  // sets per way
  localparam int unsigned NumSets     = 16;
  localparam int unsigned IndexWidth  = $clog2(NumSets);
  // whatever is left above index and offset
  localparam int unsigned TagWidth    = AddrWidth - IndexWidth - OffsetWidth;

  ////////////////////
  // port payloads
  ////////////////////

  typedef logic [LineWidth-1:0] line_t;

  // fetch request, byte address
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
  } fetch_req_t;

  // fetch response, one instruction word
  typedef struct packed {
    logic [FetchWidth-1:0] data;
  } fetch_rsp_t;

  // refill request, always line aligned
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
  } refill_req_t;

  // refill response carries the whole line
  typedef struct packed {
    line_t data;
  } refill_rsp_t;

  // tag array entry, valid bit on top
  typedef struct packed {
    logic                valid;
    logic [TagWidth-1:0] tag;
  } tag_entry_t;

  // controller states
  typedef enum logic [1:0] {
    IDLE,
    READ,
    MISS,
    FLUSH
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== logic/icache_sram.sv ====
`default_nettype none

module icache_sram
  import icache_pkg::*;
#(
  parameter type         entry_t = logic,
  parameter int unsigned Depth   = NumSets
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [IndexWidth-1:0] addr_i,
  input  entry_t                wdata_i,
  output entry_t                rdata_o
);

  // storage, no reset
  entry_t mem_q [Depth];
  // read data register
  entry_t rdata_q;

  // write port
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // read data shows up one cycle after the strobe
  // and holds until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== logic/icache_tag_store.sv ====
`default_nettype none

module icache_tag_store
  import icache_pkg::*;
#(
  parameter  int unsigned NumWays  = 4,
  localparam int unsigned WayWidth = $clog2(NumWays)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rd_en_i,
  input  logic                  vld_we_i,
  // 1 writes a valid entry on refill, 0 clears on flush
  input  logic                  vld_set_i,
  input  logic [NumWays-1:0]    way_oh_i,
  input  logic [IndexWidth-1:0] index_i,
  input  logic [TagWidth-1:0]   tag_i,
  output logic                  hit_o,
  output logic [WayWidth-1:0]   hit_way_o,
  output logic [WayWidth-1:0]   inv_way_o,
  output logic                  all_valid_o
);

  tag_entry_t         wdata;
  tag_entry_t         rdata [NumWays];
  logic [NumWays-1:0] way_req;
  logic [NumWays-1:0] hit_vec;
  logic [NumWays-1:0] vld_vec;

  // flush writes an all zero entry
  assign wdata.valid = vld_set_i;
  assign wdata.tag   = vld_set_i ? tag_i : '0;

  ////////////////////
  // tag arrays
  ////////////////////

  for (genvar i = 0; i < NumWays; i++) begin : gen_way
    // lookup reads every way
    // refill writes the victim only, flush hits all ways
    assign way_req[i] = rd_en_i | (vld_we_i & (~vld_set_i | way_oh_i[i]));

    icache_sram #(
      .entry_t ( tag_entry_t ),
      .Depth   ( NumSets     )
    ) u_tag_sram (
      .clk_i   ( clk_i      ),
      .rst_ni  ( rst_ni     ),
      .req_i   ( way_req[i] ),
      .we_i    ( vld_we_i   ),
      .addr_i  ( index_i    ),
      .wdata_i ( wdata      ),
      .rdata_o ( rdata[i]   )
    );

    // compare against the latched tag
    assign vld_vec[i] = rdata[i].valid;
    assign hit_vec[i] = rdata[i].valid && (rdata[i].tag == tag_i);
  end

  ////////////////////
  // hit and free way
  ////////////////////

  assign hit_o       = |hit_vec;
  assign all_valid_o = &vld_vec;

  // lowest index wins for both encoders
  always_comb begin
    hit_way_o = '0;
    inv_way_o = '0;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (hit_vec[i]) begin
        hit_way_o = WayWidth'(i);
      end
      if (!vld_vec[i]) begin
        inv_way_o = WayWidth'(i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/icache_top.sv ====
`default_nettype none

module icache_top
  import icache_pkg::*;
#(
  parameter int unsigned NumWays = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  input  logic        en_i,
  // fetch port
  input  logic        fetch_req_valid_i,
  input  fetch_req_t  fetch_req_i,
  output logic        fetch_req_ready_o,
  output logic        fetch_rsp_valid_o,
  output fetch_rsp_t  fetch_rsp_o,
  // refill port
  output logic        refill_req_valid_o,
  output refill_req_t refill_req_o,
  input  logic        refill_req_ready_i,
  input  logic        refill_rsp_valid_i,
  input  refill_rsp_t refill_rsp_i
);

  localparam int unsigned WayWidth = $clog2(NumWays);

  logic                   rd_en;
  logic                   wr_en;
  logic                   flush_en;
  logic                   sample;
  logic                   use_refill;
  logic                   hit;
  logic                   all_valid;
  logic [IndexWidth-1:0]  index;
  logic [OffsetWidth-1:0] offset;
  logic [TagWidth-1:0]    tag;
  logic [WayWidth-1:0]    hit_way;
  logic [WayWidth-1:0]    inv_way;
  logic [NumWays-1:0]     way_oh;

  icache_ctrl u_ctrl (
    .clk_i              ( clk_i              ),
    .rst_ni             ( rst_ni             ),
    .flush_i            ( flush_i            ),
    .en_i               ( en_i               ),
    .fetch_req_valid_i  ( fetch_req_valid_i  ),
    .fetch_req_i        ( fetch_req_i        ),
    .fetch_req_ready_o  ( fetch_req_ready_o  ),
    .fetch_rsp_valid_o  ( fetch_rsp_valid_o  ),
    .refill_req_valid_o ( refill_req_valid_o ),
    .refill_req_o       ( refill_req_o       ),
    .refill_req_ready_i ( refill_req_ready_i ),
    .refill_rsp_valid_i ( refill_rsp_valid_i ),
    .hit_i              ( hit                ),
    .rd_en_o            ( rd_en              ),
    .wr_en_o            ( wr_en              ),
    .flush_en_o         ( flush_en           ),
    .sample_o           ( sample             ),
    .use_refill_o       ( use_refill         ),
    .index_o            ( index              ),
    .offset_o           ( offset             ),
    .tag_o              ( tag                )
  );

  // refill sets a valid entry, flush clears one
  icache_tag_store #(
    .NumWays ( NumWays )
  ) u_tag_store (
    .clk_i       ( clk_i            ),
    .rst_ni      ( rst_ni           ),
    .rd_en_i     ( rd_en            ),
    .vld_we_i    ( wr_en | flush_en ),
    .vld_set_i   ( wr_en            ),
    .way_oh_i    ( way_oh           ),
    .index_i     ( index            ),
    .tag_i       ( tag              ),
    .hit_o       ( hit              ),
    .hit_way_o   ( hit_way          ),
    .inv_way_o   ( inv_way          ),
    .all_valid_o ( all_valid        )
  );

  icache_data_store #(
    .NumWays ( NumWays )
  ) u_data_store (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .rd_en_i      ( rd_en        ),
    .we_i         ( wr_en        ),
    .way_oh_i     ( way_oh       ),
    .index_i      ( index        ),
    .offset_i     ( offset       ),
    .refill_i     ( refill_rsp_i ),
    .hit_way_i    ( hit_way      ),
    .use_refill_i ( use_refill   ),
    .word_o       ( fetch_rsp_o  )
  );

  icache_victim_sel #(
    .NumWays ( NumWays )
  ) u_victim_sel (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .sample_i    ( sample    ),
    .refill_i    ( wr_en     ),
    .inv_way_i   ( inv_way   ),
    .all_valid_i ( all_valid ),
    .way_oh_o    ( way_oh    )
  );

endmodule

`default_nettype wire

// ==== logic/icache_victim_sel.sv ====
`default_nettype none

module icache_victim_sel
  import icache_pkg::*;
#(
  parameter  int unsigned NumWays  = 4,
  localparam int unsigned WayWidth = $clog2(NumWays)
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // high in the lookup cycle
  input  logic                sample_i,
  // high when a line is written
  input  logic                refill_i,
  input  logic [WayWidth-1:0] inv_way_i,
  input  logic                all_valid_i,
  output logic [NumWays-1:0]  way_oh_o
);

  logic [7:0]          lfsr_d;
  logic [7:0]          lfsr_q;
  logic [WayWidth-1:0] repl_way;
  logic [NumWays-1:0]  way_oh_q;

  // x^8 + x^6 + x^5 + x^4 + 1, maximal length
  assign lfsr_d = {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};

  // free way first, random way when the set is full
  assign repl_way = all_valid_i ? lfsr_q[WayWidth-1:0] : inv_way_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // any nonzero seed
      lfsr_q   <= 8'hA5;
      way_oh_q <= '0;
    end else begin
      // step only when a valid line gets evicted
      if (refill_i && all_valid_i) begin
        lfsr_q <= lfsr_d;
      end
      // choice frozen for the write in miss
      if (sample_i) begin
        way_oh_q <= NumWays'(1) << repl_way;
      end
    end
  end

  assign way_oh_o = way_oh_q;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module icache_tb -f icache_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vicache_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "No errors"; then
  exit 0
fi
echo "simulation reported failures"
exit 1

// ==== tb/icache_assertions.sv ====
`default_nettype none

module icache_assertions
  import icache_pkg::*;
#(
  parameter int unsigned NumWays = 4
) (
  input logic               clk_i,
  input logic               rst_ni,
  input ctrl_state_e        state_i,
  input logic [NumWays-1:0] hit_vec_i,
  // tag array write strobe, and refill versus clear select
  input logic               tag_we_i,
  input logic               tag_set_i,
  input logic               fetch_rsp_valid_i,
  input logic               refill_req_valid_i,
  input refill_req_t        refill_req_i,
  input logic               refill_req_ready_i
);

  // a line is stored in one way of its set only
  one_way_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == READ) |-> $onehot0(hit_vec_i))
    else $error("more than one way hit in a lookup");

  // stalled refill request holds valid and address
  refill_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (refill_req_valid_i && !refill_req_ready_i) |=>
      (refill_req_valid_i && $stable(refill_req_i)))
    else $error("refill request dropped or changed while stalled");

  // arrays are being cleared, nothing to answer with
  no_rsp_in_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tag_we_i && !tag_set_i) |-> !fetch_rsp_valid_i)
    else $error("fetch response during a flush");

endmodule

`default_nettype wire

// ==== tb/icache_cases.txt ====
// op addr word refills; op 0 fetch 1 flush 2 enable 3 disable 4 mark 5 refills since mark
// refills for a fetch: 0 none, 1 one, 2 either; for op 5 the minimum count
2 0000 00000000 0
0 0120 C0DE0120 1
0 0128 C0DE0128 0
0 0030 C0DE0030 1
0 1034 C0DE1034 1
0 2038 C0DE2038 1
0 303C C0DE303C 1
0 4030 C0DE4030 1
4 0000 00000000 0
0 0034 C0DE0034 2
0 1038 C0DE1038 2
0 203C C0DE203C 2
0 3030 C0DE3030 2
0 4034 C0DE4034 2
5 0000 00000000 1
0 0124 C0DE0124 0
1 0000 00000000 0
0 0124 C0DE0124 1
3 0000 00000000 0
0 0124 C0DE0124 1
0 0124 C0DE0124 1
2 0000 00000000 0
0 0128 C0DE0128 1
0 012C C0DE012C 0
0 FFF0 C0DEFFF0 1
0 FFFC C0DEFFFC 0

// ==== tb/icache_tb.sv ====
`default_nettype none

module icache_tb
  import icache_pkg::*;
();

  localparam int unsigned NumWays     = 4;
  localparam int unsigned ClkPeriod   = 100;
  localparam int unsigned ResetCycles = 16;
  // watchdog budget per case line
  localparam int unsigned CaseCycles  = 40;
  // longest single wait inside one case
  localparam int unsigned StepLimit   = 32;
  localparam int unsigned MaxCases    = 64;
  // memory word at byte address a holds a + WordBase
  localparam logic [31:0] WordBase    = 32'hC0DE_0000;
  // opcodes of the case file
  localparam logic [31:0] OpFetch     = 32'd0;
  localparam logic [31:0] OpFlush     = 32'd1;
  localparam logic [31:0] OpEnable    = 32'd2;
  localparam logic [31:0] OpDisable   = 32'd3;
  localparam logic [31:0] OpMark      = 32'd4;
  localparam logic [31:0] OpAtLeast   = 32'd5;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        flush;
  logic        en;
  logic        fetch_req_valid;
  fetch_req_t  fetch_req;
  logic        fetch_req_ready;
  logic        fetch_rsp_valid;
  fetch_rsp_t  fetch_rsp;
  logic        refill_req_valid;
  refill_req_t refill_req;
  logic        refill_req_ready;
  logic        refill_rsp_valid;
  refill_rsp_t refill_rsp;

  // four words per case: op, address, word, refills
  logic [31:0] cases_mem [MaxCases*4];
  int unsigned num_cases    = 0;
  int unsigned errors       = 0;
  int unsigned refill_count = 0;
  int unsigned rsp_count    = 0;
  int unsigned fetch_count  = 0;
  int unsigned mark_count   = 0;
  logic [15:0] lfsr         = 16'd10;
  // line the current fetch belongs to
  logic [AddrWidth-1:0] fetch_line = '0;

  always #(ClkPeriod / 2) clk = ~clk;

  icache_top #(
    .NumWays ( NumWays )
  ) dut (
    .clk_i              ( clk              ),
    .rst_ni             ( rst_n            ),
    .flush_i            ( flush            ),
    .en_i               ( en               ),
    .fetch_req_valid_i  ( fetch_req_valid  ),
    .fetch_req_i        ( fetch_req        ),
    .fetch_req_ready_o  ( fetch_req_ready  ),
    .fetch_rsp_valid_o  ( fetch_rsp_valid  ),
    .fetch_rsp_o        ( fetch_rsp        ),
    .refill_req_valid_o ( refill_req_valid ),
    .refill_req_o       ( refill_req       ),
    .refill_req_ready_i ( refill_req_ready ),
    .refill_rsp_valid_i ( refill_rsp_valid ),
    .refill_rsp_i       ( refill_rsp       )
  );

  bind icache_top icache_assertions #(
    .NumWays ( NumWays )
  ) u_assertions (
    .clk_i              ( clk_i                 ),
    .rst_ni             ( rst_ni                ),
    .state_i            ( u_ctrl.state_q        ),
    .hit_vec_i          ( u_tag_store.hit_vec   ),
    .tag_we_i           ( u_tag_store.vld_we_i  ),
    .tag_set_i          ( u_tag_store.vld_set_i ),
    .fetch_rsp_valid_i  ( fetch_rsp_valid_o     ),
    .refill_req_valid_i ( refill_req_valid_o    ),
    .refill_req_i       ( refill_req_o          ),
    .refill_req_ready_i ( refill_req_ready_i    )
  );

  ////////////////////
  // memory model
  ////////////////////

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic random_bits(input int unsigned n, output int unsigned val);
    val = 0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | 32'(lfsr[0]);
    end
  endtask

  function automatic line_t line_from_memory(input logic [AddrWidth-1:0] line_addr);
    line_t data;
    for (int w = 0; w < LineBytes / 4; w++) begin
      data[w*32 +: 32] = WordBase + 32'(line_addr) + 32'(w * 4);
    end
    return data;
  endfunction

  // ready and response each come 0 to 3 cycles late
  initial begin : memory_model
    int unsigned          stall;
    logic [AddrWidth-1:0] line_addr;
    refill_req_ready <= 1'b0;
    refill_rsp_valid <= 1'b0;
    refill_rsp       <= '0;
    forever begin
      @(negedge clk);
      if (refill_req_valid) begin
        line_addr = refill_req.addr;
        assert (line_addr == fetch_line) else begin
          $display("Mismatch at %0t: refill_req_o is %h, expected %h",
                   $time, line_addr, fetch_line);
          errors++;
        end
        random_bits(2, stall);
        repeat (stall) @(posedge clk);
        @(posedge clk);
        refill_req_ready <= 1'b1;
        // handshake on this edge
        @(posedge clk);
        refill_req_ready <= 1'b0;
        refill_count++;
        random_bits(2, stall);
        repeat (stall) @(posedge clk);
        refill_rsp_valid <= 1'b1;
        refill_rsp.data  <= line_from_memory(line_addr);
        @(posedge clk);
        refill_rsp_valid <= 1'b0;
      end
    end
  end

  // every response the DUT gives
  always @(negedge clk) begin
    if (rst_n && fetch_rsp_valid) begin
      rsp_count <= rsp_count + 1;
    end
  end

  ////////////////////
  // case steps
  ////////////////////

  // returns at a falling edge with ready high, or gives up
  task automatic wait_ready(output int unsigned low, output bit ok);
    low = 0;
    @(negedge clk);
    while (!fetch_req_ready && low < StepLimit) begin
      low++;
      @(negedge clk);
    end
    ok = fetch_req_ready;
  endtask

  // one idle cycle to take the clear, then one cycle per set
  task automatic expect_clear(input int unsigned skipped);
    int unsigned low;
    bit          ok;
    wait_ready(low, ok);
    assert (ok) else begin
      $display("fetch_req_ready_o did not return after clearing the cache");
      errors++;
    end
    assert (!ok || low + skipped == NumSets + 1) else begin
      $display("Mismatch at %0t: fetch_req_ready_o low for %0d cycles, expected %0d",
               $time, low + skipped, NumSets + 1);
      errors++;
    end
  endtask

  task automatic do_fetch(input logic [AddrWidth-1:0] addr, input logic [31:0] word,
                          input logic [31:0] refills);
    int unsigned refills_before;
    int unsigned taken;
    int unsigned latency;
    bit          ok;
    refills_before = refill_count;
    // memory is asked for whole lines only
    fetch_line     = {addr[AddrWidth-1:OffsetWidth], OffsetWidth'(0)};
    @(posedge clk);
    fetch_req_valid <= 1'b1;
    fetch_req.addr  <= addr;
    wait_ready(latency, ok);
    assert (ok) else begin
      $display("fetch of %h was never accepted", addr);
      errors++;
    end
    @(posedge clk);
    fetch_req_valid <= 1'b0;
    if (ok) begin
      latency = 1;
      @(negedge clk);
      while (!fetch_rsp_valid && latency < StepLimit) begin
        latency++;
        @(negedge clk);
      end
      assert (fetch_rsp_valid) else begin
        $display("no fetch response for %h within %0d cycles", addr, StepLimit);
        errors++;
      end
      if (fetch_rsp_valid) begin
        taken = refill_count - refills_before;
        assert (fetch_rsp.data == word) else begin
          $display("Mismatch at %0t: fetch_rsp_o is %h, expected %h",
                   $time, fetch_rsp.data, word);
          errors++;
        end
        // 2 means hit or miss are both fine
        assert (refills == 32'd2 || taken == refills) else begin
          $display("Mismatch at %0t: refill_req_o handshakes %0d, expected %0d",
                   $time, taken, refills);
          errors++;
        end
        assert (refills != 32'd0 || latency == 1) else begin
          $display("Mismatch at %0t: fetch_rsp_valid_o after %0d cycles, expected 1",
                   $time, latency);
          errors++;
        end
      end
      @(posedge clk);
      fetch_count++;
      assert (rsp_count == fetch_count) else begin
        $display("Mismatch at %0t: fetch_rsp_valid_o count %0d, expected %0d",
                 $time, rsp_count, fetch_count);
        errors++;
      end
    end
  endtask

  function automatic string op_name(input logic [31:0] op);
    case (op)
      OpFetch:   return "fetch";
      OpFlush:   return "flush";
      OpEnable:  return "enable";
      OpDisable: return "disable";
      OpMark:    return "mark";
      OpAtLeast: return "refills since mark";
      default:   return "unknown";
    endcase
  endfunction

  task automatic run_case(input int unsigned idx);
    logic [31:0]          op;
    logic [AddrWidth-1:0] addr;
    logic [31:0]          word;
    logic [31:0]          refills;
    int unsigned          errors_before;
    op            = cases_mem[idx*4];
    addr          = cases_mem[idx*4+1][AddrWidth-1:0];
    word          = cases_mem[idx*4+2];
    refills       = cases_mem[idx*4+3];
    errors_before = errors;
    assert (op <= OpAtLeast) else begin
      $display("case %0d has an unknown opcode %h", idx, op);
      errors++;
    end
    if (op == OpFetch) begin
      do_fetch(addr, word, refills);
    end else if (op == OpFlush) begin
      @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
      // the cycle with flush high is already gone
      expect_clear(1);
    end else if (op == OpEnable) begin
      @(posedge clk);
      en <= 1'b1;
      expect_clear(0);
    end else if (op == OpDisable) begin
      @(posedge clk);
      en <= 1'b0;
    end else if (op == OpMark) begin
      mark_count = refill_count;
    end else if (op == OpAtLeast) begin
      assert (refill_count - mark_count >= refills) else begin
        $display("only %0d refills since the mark, at least %0d expected",
                 refill_count - mark_count, refills);
        errors++;
      end
    end
    $display("case %0d %s %h: %s", idx, op_name(op), addr,
             (errors == errors_before) ? "ok" : "failed");
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : stimulus
    rst_n           <= 1'b0;
    flush           <= 1'b0;
    en              <= 1'b0;
    fetch_req_valid <= 1'b0;
    fetch_req       <= '0;
    // all ones marks the end of the cases
    for (int i = 0; i < MaxCases * 4; i++) begin
      cases_mem[i] = '1;
    end
    $readmemh("tb/icache_cases.txt", cases_mem);
    while (num_cases < MaxCases && cases_mem[num_cases*4] != '1) begin
      num_cases++;
    end
    assert (num_cases > 0) else begin
      $display("no cases were read from tb/icache_cases.txt");
      errors++;
    end
    repeat (ResetCycles) @(posedge clk);
    rst_n <= 1'b1;
    for (int unsigned idx = 0; idx < num_cases; idx++) begin
      run_case(idx);
    end
    // late extra responses would show up here
    repeat (4) @(posedge clk);
    assert (rsp_count == fetch_count) else begin
      $display("Mismatch at %0t: fetch_rsp_valid_o count %0d, expected %0d",
               $time, rsp_count, fetch_count);
      errors++;
    end
    $display("%0d cases, %0d fetches, %0d refills, %0d errors",
             num_cases, fetch_count, refill_count, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    wait (num_cases != 0);
    repeat (ResetCycles + num_cases * CaseCycles) @(posedge clk);
    $display("run stopped, the cases did not finish in %0d cycles",
             ResetCycles + num_cases * CaseCycles);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire
